//--- hw/mult_defs.svh
// Widths and constants shared by the multiplier RTL and testbench, pulled in with `include
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// Operand and result width
`define MULT_XLEN 32

// Halfword width seen by the short multiplier
`define MULT_HALF 16

// Width of the shift amount
`define MULT_IMM_W 5

// Width of the operator code
`define MULT_OP_W 4

// Right shift applied in the first and third upper-word steps
`define MULT_MULH_SHIFT 16

`endif

//--- hw/mult_pkg.sv
// Operator, signedness and element types of the multiplier; import wherever these are used
`default_nettype none

`include "mult_defs.svh"

package mult_pkg;

  ////////////////////
  // Operator codes
  ////////////////////

  // Codes not listed here give a zero result
  typedef enum logic [`MULT_OP_W-1:0] {
    MUL_MAC32 = 0,
    MUL_MSU32 = 1,
    MUL_I     = 2,
    MUL_IR    = 3,
    MUL_DOT8  = 4,
    MUL_DOT4  = 5,
    MUL_DOT2  = 6,
    MUL_H     = 7
  } mult_op_e;

  // Bit 0 marks operand A as signed, bit 1 operand B
  typedef logic [1:0] sign_mode_t;

  ////////////////////
  // Packed elements
  ////////////////////

  typedef logic [7:0] char_t;
  typedef logic [3:0] nibble_t;
  typedef logic [1:0] crumb_t;

endpackage

`default_nettype wire

//--- hw/dot_lane.sv
// Packed dot product accumulated onto op_c_i; elem_t sets the element width of the lane
`timescale 1ns/100ps
`default_nettype none

`include "mult_defs.svh"

module dot_lane #(
  parameter type elem_t = mult_pkg::char_t
) (
  input  logic [`MULT_XLEN-1:0] op_a_i,
  input  logic [`MULT_XLEN-1:0] op_b_i,
  input  logic [`MULT_XLEN-1:0] op_c_i,
  input  mult_pkg::sign_mode_t  signed_i,
  output logic [`MULT_XLEN-1:0] result_o
);

  localparam int unsigned elem_w = $bits(elem_t);
  localparam int unsigned n_elem = `MULT_XLEN / elem_w;

  logic [n_elem-1:0][elem_w:0]        ext_a;
  logic [n_elem-1:0][elem_w:0]        ext_b;
  logic [n_elem-1:0][`MULT_XLEN-1:0] prod;

  for (genvar i = 0; i < n_elem; i++) begin : gen_elem
    elem_t elem_a;
    elem_t elem_b;

    assign elem_a   = op_a_i[i*elem_w +: elem_w];
    assign elem_b   = op_b_i[i*elem_w +: elem_w];
    // One extra bit carries the sign, or zero when unsigned
    assign ext_a[i] = {signed_i[0] & elem_a[elem_w-1], elem_a};
    assign ext_b[i] = {signed_i[1] & elem_b[elem_w-1], elem_b};
    // Product already sign-extended to the full width
    assign prod[i]  = $signed(ext_a[i]) * $signed(ext_b[i]);
  end

  // Adder tree folded into a loop, low 32 bits only
  always_comb begin
    result_o = op_c_i;
    for (int i = 0; i < n_elem; i++) begin
      result_o = result_o + prod[i];
    end
  end

endmodule

`default_nettype wire

//--- hw/scalar_mult.sv
// Combinational scalar datapath: 32-bit MAC/MSU plus halfword multiply, accumulate, round and shift
`timescale 1ns/100ps
`default_nettype none

`include "mult_defs.svh"

module scalar_mult (
  input  mult_pkg::mult_op_e     operator_i,
  input  logic [`MULT_XLEN-1:0]  op_a_i,
  input  logic [`MULT_XLEN-1:0]  op_b_i,
  input  logic [`MULT_XLEN-1:0]  op_c_i,
  input  logic                   subword_i,
  input  mult_pkg::sign_mode_t   signed_i,
  input  logic [`MULT_IMM_W-1:0] imm_i,
  // Controls taken over by the MULH sequencer
  input  logic                   mulh_active_i,
  input  logic [1:0]             mulh_subword_i,
  input  mult_pkg::sign_mode_t   mulh_signed_i,
  input  logic [`MULT_IMM_W-1:0] mulh_imm_i,
  input  logic                   mulh_arith_i,
  input  logic [`MULT_XLEN:0]    mulh_acc_i,
  output logic [`MULT_XLEN-1:0]  int_result_o,
  output logic [`MULT_XLEN-1:0]  short_result_o,
  output logic [`MULT_XLEN+1:0]  short_mac_o
);

  import mult_pkg::*;

  ////////////////////
  // 32-bit MAC/MSU
  ////////////////////

  logic                  int_is_msu;
  logic [`MULT_XLEN-1:0] int_op_a;
  logic [`MULT_XLEN-1:0] int_op_b_corr;

  // Subtraction as (~A)*B + B, which equals -A*B
  assign int_is_msu    = (operator_i == MUL_MSU32);
  assign int_op_a      = op_a_i ^ {`MULT_XLEN{int_is_msu}};
  assign int_op_b_corr = op_b_i & {`MULT_XLEN{int_is_msu}};
  assign int_result_o  = op_c_i + int_op_b_corr + int_op_a * op_b_i;

  ////////////////////
  // Halfword path
  ////////////////////

  logic [1:0]             short_subword;
  sign_mode_t             short_signed;
  logic [`MULT_IMM_W-1:0] short_imm;
  logic                   short_arith;
  logic [`MULT_HALF:0]    short_op_a;
  logic [`MULT_HALF:0]    short_op_b;
  logic [`MULT_XLEN:0]    short_op_c;
  logic [`MULT_XLEN+1:0]  short_mul;
  logic [`MULT_XLEN-1:0]  round_tmp;
  logic [`MULT_XLEN-1:0]  short_round;
  logic [`MULT_XLEN+1:0]  short_mac;
  logic                   mac_msb1;
  logic                   mac_msb0;
  logic [`MULT_XLEN+1:0]  short_shifted;

  // Sequencer overrides the port controls while MULH runs
  assign short_subword = mulh_active_i ? mulh_subword_i : {2{subword_i}};
  assign short_signed  = mulh_active_i ? mulh_signed_i  : signed_i;
  assign short_imm     = mulh_active_i ? mulh_imm_i     : imm_i;
  assign short_arith   = mulh_active_i ? mulh_arith_i   : signed_i[0];

  // Half of 2^imm, zero when imm is zero
  assign round_tmp   = {{(`MULT_XLEN-1){1'b0}}, 1'b1} << imm_i;
  assign short_round = (operator_i == MUL_IR) ? {1'b0, round_tmp[`MULT_XLEN-1:1]} : '0;

  assign short_op_a[`MULT_HALF-1:0] = short_subword[0] ? op_a_i[`MULT_XLEN-1:`MULT_HALF]
                                                       : op_a_i[`MULT_HALF-1:0];
  assign short_op_b[`MULT_HALF-1:0] = short_subword[1] ? op_b_i[`MULT_XLEN-1:`MULT_HALF]
                                                       : op_b_i[`MULT_HALF-1:0];
  assign short_op_a[`MULT_HALF]     = short_signed[0] & short_op_a[`MULT_HALF-1];
  assign short_op_b[`MULT_HALF]     = short_signed[1] & short_op_b[`MULT_HALF-1];

  // Accumulator is the carry plus partial sum during MULH
  assign short_op_c = mulh_active_i ? mulh_acc_i : {op_c_i[`MULT_XLEN-1], op_c_i};

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = $signed(short_op_c) + $signed(short_mul) + $signed({1'b0, short_round});

  // MULH keeps the two extra sum bits, the short ops extend from bit 31
  assign mac_msb1 = mulh_active_i ? short_mac[`MULT_XLEN+1] : short_mac[`MULT_XLEN-1];
  assign mac_msb0 = mulh_active_i ? short_mac[`MULT_XLEN]   : short_mac[`MULT_XLEN-1];

  assign short_shifted  = $signed({short_arith & mac_msb1, short_arith & mac_msb0,
                                   short_mac[`MULT_XLEN-1:0]}) >>> short_imm;
  assign short_result_o = short_shifted[`MULT_XLEN-1:0];
  assign short_mac_o    = short_mac;

endmodule

`default_nettype wire

//--- hw/mulh_ctrl.sv
// Four-step sequencer for MULH over halfword products, holding the running sum and its carry
`timescale 1ns/100ps
`default_nettype none

`include "mult_defs.svh"

module mulh_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  mult_pkg::mult_op_e     operator_i,
  input  mult_pkg::sign_mode_t   signed_i,
  input  logic                   ex_ready_i,
  input  logic [`MULT_XLEN+1:0]  short_mac_i,
  input  logic [`MULT_XLEN-1:0]  short_result_i,
  output logic                   active_o,
  output logic [1:0]             subword_o,
  output mult_pkg::sign_mode_t   signed_o,
  output logic [`MULT_IMM_W-1:0] imm_o,
  output logic                   arith_o,
  output logic [`MULT_XLEN:0]    acc_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  import mult_pkg::*;

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  localparam logic [`MULT_IMM_W-1:0] mulh_shift = `MULT_MULH_SHIFT;

  mulh_state_e           state_q;
  mulh_state_e           state_d;
  logic [`MULT_XLEN-1:0] psum_q;
  logic [`MULT_XLEN-1:0] psum_d;
  logic                  carry_q;
  logic                  carry_d;

  assign acc_o = {carry_q, psum_q};

  ////////////////////
  // Step control
  ////////////////////

  always_comb begin
    state_d      = state_q;
    psum_d       = psum_q;
    carry_d      = carry_q;
    active_o     = 1'b1;
    subword_o    = 2'b00;
    signed_o     = 2'b00;
    imm_o        = '0;
    arith_o      = 1'b0;
    ready_o      = 1'b0;
    multicycle_o = 1'b0;

    case (state_q)
      IDLE: begin
        active_o = 1'b0;
        ready_o  = 1'b1;
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      // AL*BL, unsigned, only its upper half is kept
      STEP0: begin
        multicycle_o = 1'b1;
        imm_o        = mulh_shift;
        psum_d       = short_result_i;
        state_d      = STEP1;
      end
      // AL*BH, signed only through B; the 33-bit sum keeps its carry
      STEP1: begin
        multicycle_o = 1'b1;
        subword_o    = 2'b10;
        signed_o     = {signed_i[1], 1'b0};
        arith_o      = 1'b1;
        psum_d       = short_result_i;
        carry_d      = short_mac_i[`MULT_XLEN];
        state_d      = STEP2;
      end
      // AH*BL, then shift; carries fall out with the shift
      STEP2: begin
        multicycle_o = 1'b1;
        subword_o    = 2'b01;
        signed_o     = {1'b0, signed_i[0]};
        imm_o        = mulh_shift;
        arith_o      = 1'b1;
        psum_d       = short_result_i;
        carry_d      = 1'b0;
        state_d      = FINISH;
      end
      // AH*BH onto the sum, result held until taken
      FINISH: begin
        subword_o = 2'b11;
        signed_o  = signed_i;
        ready_o   = 1'b1;
        if (ex_ready_i) begin
          psum_d  = '0;
          carry_d = 1'b0;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      psum_q  <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      psum_q  <= psum_d;
      carry_q <= carry_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/mult_top.sv
// Multiplier top for the execute stage: scalar path, MULH sequencer and dot lanes behind one result
`timescale 1ns/100ps
`default_nettype none

`include "mult_defs.svh"

module mult_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  mult_pkg::mult_op_e     operator_i,
  input  mult_pkg::sign_mode_t   signed_i,
  input  logic                   subword_i,
  input  logic [`MULT_IMM_W-1:0] imm_i,
  input  mult_pkg::sign_mode_t   dot_signed_i,
  input  logic [`MULT_XLEN-1:0]  op_a_i,
  input  logic [`MULT_XLEN-1:0]  op_b_i,
  input  logic [`MULT_XLEN-1:0]  op_c_i,
  input  logic                   ex_ready_i,
  output logic [`MULT_XLEN-1:0]  result_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  import mult_pkg::*;

  logic                   mulh_active;
  logic [1:0]             mulh_subword;
  sign_mode_t             mulh_signed;
  logic [`MULT_IMM_W-1:0] mulh_imm;
  logic                   mulh_arith;
  logic [`MULT_XLEN:0]    mulh_acc;
  logic [`MULT_XLEN-1:0]  int_result;
  logic [`MULT_XLEN-1:0]  short_result;
  logic [`MULT_XLEN+1:0]  short_mac;
  logic [`MULT_XLEN-1:0]  dot8_result;
  logic [`MULT_XLEN-1:0]  dot4_result;
  logic [`MULT_XLEN-1:0]  dot2_result;

  ////////////////////
  // Scalar path
  ////////////////////

  scalar_mult i_scalar (
    .operator_i     (operator_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .subword_i      (subword_i),
    .signed_i       (signed_i),
    .imm_i          (imm_i),
    .mulh_active_i  (mulh_active),
    .mulh_subword_i (mulh_subword),
    .mulh_signed_i  (mulh_signed),
    .mulh_imm_i     (mulh_imm),
    .mulh_arith_i   (mulh_arith),
    .mulh_acc_i     (mulh_acc),
    .int_result_o   (int_result),
    .short_result_o (short_result),
    .short_mac_o    (short_mac)
  );

  mulh_ctrl i_mulh_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator_i),
    .signed_i       (signed_i),
    .ex_ready_i     (ex_ready_i),
    .short_mac_i    (short_mac),
    .short_result_i (short_result),
    .active_o       (mulh_active),
    .subword_o      (mulh_subword),
    .signed_o       (mulh_signed),
    .imm_o          (mulh_imm),
    .arith_o        (mulh_arith),
    .acc_o          (mulh_acc),
    .ready_o        (ready_o),
    .multicycle_o   (multicycle_o)
  );

  ////////////////////
  // Dot-product path
  ////////////////////

  dot_lane #(.elem_t(char_t)) i_dot8 (
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .op_c_i   (op_c_i),
    .signed_i (dot_signed_i),
    .result_o (dot8_result)
  );

  dot_lane #(.elem_t(nibble_t)) i_dot4 (
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .op_c_i   (op_c_i),
    .signed_i (dot_signed_i),
    .result_o (dot4_result)
  );

  dot_lane #(.elem_t(crumb_t)) i_dot2 (
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .op_c_i   (op_c_i),
    .signed_i (dot_signed_i),
    .result_o (dot2_result)
  );

  // Result select
  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32:  result_o = int_result;
      MUL_I, MUL_IR, MUL_H:  result_o = short_result;
      MUL_DOT8:              result_o = dot8_result;
      MUL_DOT4:              result_o = dot4_result;
      MUL_DOT2:              result_o = dot2_result;
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- tests/mult_model.svh
// Reference model functions for the multiplier operations that the testbench includes in its body
`ifndef MULT_MODEL_SVH
`define MULT_MODEL_SVH

// 32-bit accumulate or subtract of the full product
function automatic logic [31:0] mac32_ref(input mult_op_e op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] c);
  if (op == MUL_MSU32) return c - a * b;
  else return c + a * b;
endfunction

// Halfword product plus accumulator and rounding, then shifted right
function automatic logic [31:0] halfword_ref(input mult_op_e op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] c,
                                             input logic subword, input sign_mode_t sgn,
                                             input logic [4:0] imm);
  logic [15:0] ha;
  logic [15:0] hb;
  logic [31:0] ea;
  logic [31:0] eb;
  logic [31:0] rnd;
  logic [31:0] sum;
  ha  = subword ? a[31:16] : a[15:0];
  hb  = subword ? b[31:16] : b[15:0];
  ea  = sgn[0] ? {{16{ha[15]}}, ha} : {16'h0000, ha};
  eb  = sgn[1] ? {{16{hb[15]}}, hb} : {16'h0000, hb};
  rnd = (op == MUL_IR && imm != 0) ? (32'd1 << (imm - 1)) : 32'd0;
  sum = c + ea * eb + rnd;
  if (sgn[0]) return $signed(sum) >>> imm;
  else return sum >> imm;
endfunction

// Upper word of the 64-bit product with each operand extended by its own mode
function automatic logic [31:0] mulh_ref(input logic [31:0] a, input logic [31:0] b,
                                         input sign_mode_t sgn);
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] prod;
  ea   = sgn[0] ? {{32{a[31]}}, a} : {32'h0, a};
  eb   = sgn[1] ? {{32{b[31]}}, b} : {32'h0, b};
  prod = ea * eb;
  return prod[63:32];
endfunction

// Sum of element products of the given width on top of c
function automatic logic [31:0] dot_ref(input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] c, input sign_mode_t sgn,
                                        input int width);
  int          ea;
  int          eb;
  logic [31:0] acc;
  acc = c;
  for (int i = 0; i < 32 / width; i++) begin
    ea = (a >> (i * width)) & ((32'd1 << width) - 1);
    eb = (b >> (i * width)) & ((32'd1 << width) - 1);
    if (sgn[0] && ea[width-1]) ea = ea - (1 << width);
    if (sgn[1] && eb[width-1]) eb = eb - (1 << width);
    acc = acc + ea * eb;
  end
  return acc;
endfunction

`endif

//--- tests/tb_mult_top.sv
// Random testbench that checks mult_top against the included model when built with all.f
`timescale 1ns/100ps
`default_nettype none

`include "mult_defs.svh"

module tb_mult_top;

  import mult_pkg::*;

  `include "mult_model.svh"

  localparam int reset_cycles = 16;
  localparam int n_ops        = 400;
  localparam int max_stall    = 8;
  localparam int max_cycles   = reset_cycles + n_ops * (6 + max_stall);

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   enable_i;
  mult_op_e               operator_i;
  sign_mode_t             signed_i;
  logic                   subword_i;
  logic [`MULT_IMM_W-1:0] imm_i;
  sign_mode_t             dot_signed_i;
  logic [`MULT_XLEN-1:0]  op_a_i;
  logic [`MULT_XLEN-1:0]  op_b_i;
  logic [`MULT_XLEN-1:0]  op_c_i;
  logic                   ex_ready_i;
  logic [`MULT_XLEN-1:0]  result_o;
  logic                   ready_o;
  logic                   multicycle_o;
  integer                 seed;
  int                     cycle_count = 0;

  mult_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .operator_i   (operator_i),
    .signed_i     (signed_i),
    .subword_i    (subword_i),
    .imm_i        (imm_i),
    .dot_signed_i (dot_signed_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_c_i       (op_c_i),
    .ex_ready_i   (ex_ready_i),
    .result_o     (result_o),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  always #2 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run hung, the cycle limit of %0d was reached", max_cycles);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_random(input mult_op_e op);
    int mode;
    mode         = {$random(seed)} % 3;
    operator_i   = op;
    op_a_i       = $random(seed);
    op_b_i       = $random(seed);
    op_c_i       = $random(seed);
    subword_i    = $random(seed);
    imm_i        = $random(seed);
    dot_signed_i = $random(seed);
    // Scalar modes 00, 01 and 11 only
    signed_i     = (mode == 0) ? 2'b00 : (mode == 1) ? 2'b01 : 2'b11;
  endtask

  task automatic comb_op_test(input mult_op_e op);
    logic [31:0] expected;
    @(posedge clk);
    #1;
    drive_random(op);
    enable_i   = 1'b1;
    ex_ready_i = $random(seed);
    case (op)
      MUL_MAC32, MUL_MSU32: expected = mac32_ref(op, op_a_i, op_b_i, op_c_i);
      MUL_I, MUL_IR: expected = halfword_ref(op, op_a_i, op_b_i, op_c_i, subword_i,
                                             signed_i, imm_i);
      MUL_DOT8: expected = dot_ref(op_a_i, op_b_i, op_c_i, dot_signed_i, $bits(char_t));
      MUL_DOT4: expected = dot_ref(op_a_i, op_b_i, op_c_i, dot_signed_i, $bits(nibble_t));
      default:  expected = dot_ref(op_a_i, op_b_i, op_c_i, dot_signed_i, $bits(crumb_t));
    endcase
    @(negedge clk);
    check_value({op.name(), " ready"}, 32'd1, ready_o);
    check_value(op.name(), expected, result_o);
  endtask

  task automatic mulh_op_test();
    int          stall;
    int          low_cycles;
    int          mc_cycles;
    logic [31:0] expected;
    @(posedge clk);
    #1;
    drive_random(MUL_H);
    stall      = {$random(seed)} % (max_stall + 1);
    enable_i   = 1'b1;
    ex_ready_i = (stall == 0);
    expected   = mulh_ref(op_a_i, op_b_i, signed_i);
    low_cycles = 0;
    mc_cycles  = 0;
    @(negedge clk);
    while (!ready_o) begin
      low_cycles++;
      if (multicycle_o) mc_cycles++;
      @(negedge clk);
    end
    check_value("MUL_H ready low cycles", 32'd4, low_cycles);
    check_value("MUL_H multicycle cycles", 32'd3, mc_cycles);
    check_value("MUL_H multicycle in finish", 32'd0, multicycle_o);
    check_value("MUL_H", expected, result_o);
    // Result and ready must hold under back-pressure
    for (int i = 1; i <= stall; i++) begin
      @(posedge clk);
      #1;
      if (i == stall) ex_ready_i = 1'b1;
      @(negedge clk);
      check_value("MUL_H ready under stall", 32'd1, ready_o);
      check_value("MUL_H held under stall", expected, result_o);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int k;
    seed         = 32'hadf1f9bf;
    rst_n        = 1'b0;
    enable_i     = 1'b0;
    operator_i   = MUL_MAC32;
    signed_i     = 2'b00;
    subword_i    = 1'b0;
    imm_i        = '0;
    dot_signed_i = 2'b00;
    op_a_i       = '0;
    op_b_i       = '0;
    op_c_i       = '0;
    ex_ready_i   = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ready after reset", 32'd1, ready_o);
    check_value("multicycle after reset", 32'd0, multicycle_o);

    for (int i = 0; i < n_ops; i++) begin
      k = {$random(seed)} % 8;
      if (mult_op_e'(k) == MUL_H) mulh_op_test();
      else comb_op_test(mult_op_e'(k));
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
+incdir+tests
hw/mult_pkg.sv
hw/dot_lane.sv
hw/scalar_mult.sv
hw/mulh_ctrl.sv
hw/mult_top.sv
tests/tb_mult_top.sv

//--- Bender.yml
package:
  name: mult_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mult_pkg.sv
      - hw/dot_lane.sv
      - hw/scalar_mult.sv
      - hw/mulh_ctrl.sv
      - hw/mult_top.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tb_mult_top.sv
